/* Bender.yml */
package:
  name: mem_subsys

sources:
  - common/mem_pkg.sv
  - mem_stage/lsu_ext.sv
  - mem_stage/mem_stage.sv
  - src/clint.sv
  - src/data_ram.sv
  - src/mem_subsys_top.sv
  - target: any(simulation, test)
    files:
      - sim/mem_subsys_props.sv
      - sim/tb_mem_subsys.sv

/* common/mem_pkg.sv */
`default_nettype none

package mem_pkg;

  localparam int XLEN      = 32;
  localparam int RAM_WORDS = 1024;
  localparam int RAM_AW    = $clog2(RAM_WORDS); // word index taken from addr[11:2]

  // memory op code carried down from ex
  typedef enum logic [3:0] {
    MEMOP_NONE = 4'd0,
    MEMOP_LB   = 4'd1,
    MEMOP_LBU  = 4'd2,
    MEMOP_LH   = 4'd3,
    MEMOP_LHU  = 4'd4,
    MEMOP_LW   = 4'd5,
    MEMOP_SB   = 4'd6,
    MEMOP_SH   = 4'd7,
    MEMOP_SW   = 4'd8
  } memop_e;

  // clint register map
  localparam logic [XLEN-1:0] MTIME_ADDR_LO    = 32'h0200_BFF8;
  localparam logic [XLEN-1:0] MTIME_ADDR_HI    = 32'h0200_BFFC;
  localparam logic [XLEN-1:0] MTIMECMP_ADDR_LO = 32'h0200_4000;
  localparam logic [XLEN-1:0] MTIMECMP_ADDR_HI = 32'h0200_4004;

  // one instruction from ex/mem
  typedef struct packed {
    logic [XLEN-1:0] inst_addr;
    logic [4:0]      rd_idx;
    memop_e          mem_op;
    logic [XLEN-1:0] alu_data;  // address for loads and stores
    logic [XLEN-1:0] rs2_data;  // store value
  } exmem_t;

  // result towards mem/wb
  typedef struct packed {
    logic [XLEN-1:0] inst_addr;
    logic [4:0]      rd_idx;
    logic [XLEN-1:0] wb_data;
  } memwb_t;

  typedef struct packed {
    logic            valid;
    logic            we;
    logic [XLEN-1:0] addr;
    logic [3:0]      mask;   // byte lanes
    logic [XLEN-1:0] wdata;
  } dmem_req_t;

  typedef struct packed {
    logic            valid;
    logic            we;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
  } clint_req_t;

  typedef struct packed {
    logic [XLEN-1:0] hi;
    logic [XLEN-1:0] lo;
  } timer_half_t;

  // 64-bit timer, compared whole but accessed per half on the bus
  typedef union packed {
    logic [2*XLEN-1:0] full;
    timer_half_t       half;
  } timer_word_u;

endpackage

`default_nettype wire

/* flist.f */
common/mem_pkg.sv
mem_stage/lsu_ext.sv
mem_stage/mem_stage.sv
src/clint.sv
src/data_ram.sv
src/mem_subsys_top.sv
sim/mem_subsys_props.sv
sim/tb_mem_subsys.sv

/* mem_stage/lsu_ext.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_ext (
  input  logic [mem_pkg::XLEN-1:0] data_i,
  input  logic [1:0]               offset_i,
  input  logic [2:0]               size_i,    // one-hot {4, 2, 1} bytes
  input  logic                     signed_i,
  output logic [mem_pkg::XLEN-1:0] data_o
);

  logic [mem_pkg::XLEN-1:0] shifted;
  logic                     fill;

  // bring the addressed lane down to bit 0
  assign shifted = data_i >> {offset_i, 3'b000};

  always_comb begin
    fill = 1'b0;
    unique case (1'b1)
      size_i[0]: begin
        fill   = signed_i & shifted[7];
        data_o = {{24{fill}}, shifted[7:0]};
      end
      size_i[1]: begin
        fill   = signed_i & shifted[15];
        data_o = {{16{fill}}, shifted[15:0]};
      end
      default: begin
        data_o = shifted;  // full word
      end
    endcase
  end

endmodule

`default_nettype wire

/* mem_stage/mem_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
  input  mem_pkg::exmem_t            exmem_i,
  output mem_pkg::dmem_req_t         dmem_req_o,
  input  logic                       dmem_ready_i,
  input  logic [mem_pkg::XLEN-1:0]   dmem_rdata_i,
  output mem_pkg::clint_req_t        clint_req_o,
  input  logic [mem_pkg::XLEN-1:0]   clint_rdata_i,
  output mem_pkg::memwb_t            memwb_o,
  output logic                       stall_o
);

  logic                     op_none;
  logic                     op_lb, op_lbu, op_lh, op_lhu, op_lw;
  logic                     op_sb, op_sh, op_sw;
  logic                     is_load, is_store, ls_valid;
  logic                     ls_signed;
  logic [2:0]               ls_size;     // one-hot {4, 2, 1} bytes
  logic [3:0]               base_mask;
  logic [1:0]               offset;
  logic [mem_pkg::XLEN-1:0] addr;
  logic [mem_pkg::XLEN-1:0] wdata_shifted;
  logic                     is_clint;
  logic                     ram_access;
  logic [mem_pkg::XLEN-1:0] rdata_sel;
  logic [mem_pkg::XLEN-1:0] load_data;

  assign op_none = (exmem_i.mem_op == mem_pkg::MEMOP_NONE);
  assign op_lb   = (exmem_i.mem_op == mem_pkg::MEMOP_LB);
  assign op_lbu  = (exmem_i.mem_op == mem_pkg::MEMOP_LBU);
  assign op_lh   = (exmem_i.mem_op == mem_pkg::MEMOP_LH);
  assign op_lhu  = (exmem_i.mem_op == mem_pkg::MEMOP_LHU);
  assign op_lw   = (exmem_i.mem_op == mem_pkg::MEMOP_LW);
  assign op_sb   = (exmem_i.mem_op == mem_pkg::MEMOP_SB);
  assign op_sh   = (exmem_i.mem_op == mem_pkg::MEMOP_SH);
  assign op_sw   = (exmem_i.mem_op == mem_pkg::MEMOP_SW);

  assign is_load   = op_lb | op_lbu | op_lh | op_lhu | op_lw;
  assign is_store  = op_sb | op_sh | op_sw;
  assign ls_valid  = is_load | is_store;
  assign ls_signed = op_lb | op_lh;  // lw needs no extension
  assign ls_size   = {op_lw | op_sw, op_lh | op_lhu | op_sh, op_lb | op_lbu | op_sb};

  assign addr   = exmem_i.alu_data;
  assign offset = addr[1:0];

  // lanes before alignment
  assign base_mask = ({4{ls_size[0]}} & 4'b0001)
                   | ({4{ls_size[1]}} & 4'b0011)
                   | ({4{ls_size[2]}} & 4'b1111);

  assign wdata_shifted = exmem_i.rs2_data << {offset, 3'b000};

  assign is_clint = (addr == mem_pkg::MTIME_ADDR_LO)
                  | (addr == mem_pkg::MTIME_ADDR_HI)
                  | (addr == mem_pkg::MTIMECMP_ADDR_LO)
                  | (addr == mem_pkg::MTIMECMP_ADDR_HI);

  assign ram_access = ls_valid & ~is_clint;

  always_comb begin
    dmem_req_o.valid = ram_access & ~dmem_ready_i;  // held until the ram answers
    dmem_req_o.we    = is_store;
    dmem_req_o.addr  = addr;
    dmem_req_o.mask  = base_mask << offset;  // misaligned spill is dropped
    dmem_req_o.wdata = wdata_shifted;
  end

  always_comb begin
    clint_req_o.valid = ls_valid & is_clint;
    clint_req_o.we    = is_store;
    clint_req_o.addr  = addr;
    clint_req_o.wdata = wdata_shifted;
  end

  assign stall_o   = dmem_req_o.valid;
  assign rdata_sel = is_clint ? clint_rdata_i : dmem_rdata_i;

  lsu_ext u_lsu_ext (
    .data_i   (rdata_sel),
    .offset_i (offset),
    .size_i   (ls_size),
    .signed_i (ls_signed),
    .data_o   (load_data)
  );

  always_comb begin
    memwb_o.inst_addr = exmem_i.inst_addr;
    memwb_o.rd_idx    = exmem_i.rd_idx;
    if (is_load) begin
      memwb_o.wb_data = load_data;
    end else if (op_none) begin
      memwb_o.wb_data = exmem_i.alu_data;  // alu result passes through
    end else begin
      memwb_o.wb_data = '0;                // stores write nothing back
    end
  end

endmodule

`default_nettype wire

/* sim/mem_subsys_props.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_props (
  input logic clk_i,
  input logic reset_i,
  input logic dmem_valid_i,
  input logic dmem_ready_i,
  input logic clint_valid_i,
  input logic stall_i
);

  a_one_target: assert property (@(posedge clk_i) disable iff (reset_i)
    !(dmem_valid_i && clint_valid_i))
    else $error("ram and clint requests valid together");

  a_ready_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
    dmem_ready_i |=> !dmem_ready_i)
    else $error("ram ready high two cycles in a row");

  a_ready_next: assert property (@(posedge clk_i) disable iff (reset_i)
    dmem_valid_i |=> dmem_ready_i)
    else $error("ram request not answered in the next cycle");

  a_stall_is_valid: assert property (@(posedge clk_i) disable iff (reset_i)
    stall_i == dmem_valid_i)
    else $error("stall differs from ram request valid");

endmodule

// mem_stage has no clock of its own, so attach at the top around it
bind mem_subsys_top mem_subsys_props u_mem_subsys_props (
  .clk_i         (clk),
  .reset_i       (reset_i),
  .dmem_valid_i  (dmem_req.valid),
  .dmem_ready_i  (dmem_ready),
  .clint_valid_i (clint_req.valid),
  .stall_i       (stall_o)
);

`default_nettype wire

/* sim/tb_mem_subsys.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys;

  localparam logic [31:0] WIN_BASE  = 32'h0000_0400;  // 64-word window
  localparam int          STALL_MAX = 8;

  logic            clk;
  logic            reset_i;
  mem_pkg::exmem_t exmem;
  mem_pkg::memwb_t memwb;
  logic            stall;
  logic            timer_irq;

  logic [31:0] lfsr = 32'h32f3_39cf;
  logic [7:0]  ram_m [0:4095];  // byte mirror by addr[11:0]
  logic [63:0] mtime_m;
  logic [63:0] cmp_m;
  logic        irq_m;

  mem_subsys_top u_mem_subsys_top (
    .clk         (clk),
    .reset_i     (reset_i),
    .exmem_i     (exmem),
    .memwb_o     (memwb),
    .stall_o     (stall),
    .timer_irq_o (timer_irq)
  );

  always #2 clk = ~clk;

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic logic is_clint_addr(input logic [31:0] a);
    return a == mem_pkg::MTIME_ADDR_LO || a == mem_pkg::MTIME_ADDR_HI ||
           a == mem_pkg::MTIMECMP_ADDR_LO || a == mem_pkg::MTIMECMP_ADDR_HI;
  endfunction

  // expected load value from the byte mirror or the timer model
  function automatic logic [31:0] load_model(input mem_pkg::memop_e op, input logic [31:0] a);
    logic [31:0] w;
    logic [11:0] base;
    base = {a[11:2], 2'b00};
    case (a)
      mem_pkg::MTIME_ADDR_LO:    w = mtime_m[31:0];
      mem_pkg::MTIME_ADDR_HI:    w = mtime_m[63:32];
      mem_pkg::MTIMECMP_ADDR_LO: w = cmp_m[31:0];
      mem_pkg::MTIMECMP_ADDR_HI: w = cmp_m[63:32];
      default:                   w = {ram_m[base+3], ram_m[base+2], ram_m[base+1], ram_m[base]};
    endcase
    w = w >> (8 * a[1:0]);
    case (op)
      mem_pkg::MEMOP_LB:  return {{24{w[7]}}, w[7:0]};
      mem_pkg::MEMOP_LBU: return {24'h0, w[7:0]};
      mem_pkg::MEMOP_LH:  return {{16{w[15]}}, w[15:0]};
      mem_pkg::MEMOP_LHU: return {16'h0, w[15:0]};
      default:            return w;
    endcase
  endfunction

  // lanes past byte 3 are dropped
  task automatic store_model(input mem_pkg::memop_e op, input logic [31:0] a,
                             input logic [31:0] v);
    int          nbytes;
    int          off;
    logic [11:0] base;
    nbytes = (op == mem_pkg::MEMOP_SB) ? 1 : (op == mem_pkg::MEMOP_SH) ? 2 : 4;
    off    = a[1:0];
    base   = {a[11:2], 2'b00};
    for (int b = off; b < 4 && b < off + nbytes; b++) begin
      ram_m[base + b] = v[8*(b - off) +: 8];
    end
  endtask

  task automatic check(input string name, input logic [63:0] act, input logic [63:0] exp);
    if (act !== exp) begin
      $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, act, exp);
      $display("TEST RESULT: FAIL");
      $fatal(1, "check failed");
    end
  endtask

  // one instruction through the stage, held while stalled
  task automatic issue(input mem_pkg::memop_e op, input logic [31:0] a, input logic [31:0] v);
    int          stalls;
    logic        ram_op;
    logic        st_op;
    logic [31:0] exp_wb;
    @(posedge clk);
    #1;
    exmem.inst_addr = rand_bits(30) << 2;
    exmem.rd_idx    = rand_bits(5);
    exmem.mem_op    = op;
    exmem.alu_data  = a;
    exmem.rs2_data  = v;
    st_op  = op inside {mem_pkg::MEMOP_SB, mem_pkg::MEMOP_SH, mem_pkg::MEMOP_SW};
    ram_op = (op != mem_pkg::MEMOP_NONE) && !is_clint_addr(a);
    #1;
    stalls = 0;
    while (stall) begin
      stalls++;
      if (stalls > STALL_MAX) begin
        $display("stall_o stayed high for %0d cycles on %s", stalls, op.name());
        $display("TEST RESULT: FAIL");
        $fatal(1, "timeout");
      end
      @(posedge clk);
      #2;
    end
    check("stall_o cycles", stalls, ram_op);
    if (op == mem_pkg::MEMOP_NONE) exp_wb = a;
    else if (st_op) exp_wb = '0;
    else exp_wb = load_model(op, a);
    check("memwb_o.wb_data", memwb.wb_data, exp_wb);
    check("memwb_o.inst_addr", memwb.inst_addr, exmem.inst_addr);
    check("memwb_o.rd_idx", memwb.rd_idx, exmem.rd_idx);
    if (ram_op && st_op) store_model(op, a, v);
  endtask

  task automatic wait_irq(input logic level);
    int n;
    n = 0;
    while (timer_irq !== level) begin
      n++;
      if (n > 64) begin
        $display("timer_irq_o did not reach %0b within %0d cycles", level, n);
        $display("TEST RESULT: FAIL");
        $fatal(1, "timeout");
      end
      @(posedge clk);
      #2;
    end
  endtask

  // timer model, counts every edge unless a half is written
  always @(posedge clk) begin : timer_model
    logic [63:0] nxt;
    if (reset_i) begin
      mtime_m <= '0;
      cmp_m   <= '1;
      irq_m   <= 1'b0;
    end else begin
      irq_m <= (mtime_m >= cmp_m);
      nxt = mtime_m + 64'd1;
      if (exmem.mem_op == mem_pkg::MEMOP_SW) begin
        case (exmem.alu_data)
          mem_pkg::MTIME_ADDR_LO:    nxt[31:0] = exmem.rs2_data;
          mem_pkg::MTIME_ADDR_HI:    nxt[63:32] = exmem.rs2_data;
          mem_pkg::MTIMECMP_ADDR_LO: cmp_m[31:0] <= exmem.rs2_data;
          mem_pkg::MTIMECMP_ADDR_HI: cmp_m[63:32] <= exmem.rs2_data;
          default: ;
        endcase
      end
      mtime_m <= nxt;
    end
  end

  always @(negedge clk) begin
    if (!reset_i) check("timer_irq_o", timer_irq, irq_m);
  end

  initial begin
    mem_pkg::memop_e op;
    logic [31:0]     a;
    int              n;
    clk     = 1'b0;
    reset_i = 1'b1;
    exmem   = '0;  // NONE op
    repeat (5) @(posedge clk);
    #1;
    reset_i = 1'b0;

    for (int w = 0; w < 64; w++) issue(mem_pkg::MEMOP_SW, WIN_BASE + 4 * w, rand_bits(32));
    issue(mem_pkg::MEMOP_LW, mem_pkg::MTIME_ADDR_LO, 32'h0);
    issue(mem_pkg::MEMOP_LW, mem_pkg::MTIME_ADDR_HI, 32'h0);

    for (int i = 0; i < 600; i++) begin
      n = rand_bits(4);
      if (n == 0) begin
        case (rand_bits(2))
          0:       a = mem_pkg::MTIME_ADDR_LO;
          1:       a = mem_pkg::MTIME_ADDR_HI;
          2:       a = mem_pkg::MTIMECMP_ADDR_LO;
          default: a = mem_pkg::MTIMECMP_ADDR_HI;
        endcase
        op = rand_bits(1) ? mem_pkg::MEMOP_LW : mem_pkg::MEMOP_SW;
      end else if (n < 4) begin
        op = mem_pkg::MEMOP_NONE;
        a  = rand_bits(32);
      end else begin
        op = mem_pkg::memop_e'(4'(rand_bits(3)) + 4'd1);
        a  = WIN_BASE + rand_bits(8);
      end
      issue(op, a, rand_bits(32));
    end

    // compare a few cycles ahead, then push it out again
    issue(mem_pkg::MEMOP_SW, mem_pkg::MTIME_ADDR_LO, 32'h0);
    issue(mem_pkg::MEMOP_SW, mem_pkg::MTIME_ADDR_HI, 32'h0);
    issue(mem_pkg::MEMOP_SW, mem_pkg::MTIMECMP_ADDR_HI, 32'h0);
    issue(mem_pkg::MEMOP_SW, mem_pkg::MTIMECMP_ADDR_LO, 32'd20);
    issue(mem_pkg::MEMOP_NONE, 32'h0, 32'h0);
    wait_irq(1'b1);
    issue(mem_pkg::MEMOP_SW, mem_pkg::MTIMECMP_ADDR_LO, mtime_m[31:0] + 32'd1000);
    issue(mem_pkg::MEMOP_NONE, 32'h0, 32'h0);
    wait_irq(1'b0);

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* src/clint.sv */
`timescale 1ns/1ps
`default_nettype none

module clint (
  input  logic                     clk,
  input  logic                     reset_i,
  input  mem_pkg::clint_req_t      req_i,
  output logic [mem_pkg::XLEN-1:0] rdata_o,
  output logic                     timer_irq_o
);

  mem_pkg::timer_word_u mtime;
  mem_pkg::timer_word_u mtimecmp;
  mem_pkg::timer_word_u mtime_n;
  logic                 wr_en;

  assign wr_en = req_i.valid & req_i.we;

  // read mux, no wait state
  always_comb begin
    case (req_i.addr)
      mem_pkg::MTIME_ADDR_LO:    rdata_o = mtime.half.lo;
      mem_pkg::MTIME_ADDR_HI:    rdata_o = mtime.half.hi;
      mem_pkg::MTIMECMP_ADDR_LO: rdata_o = mtimecmp.half.lo;
      mem_pkg::MTIMECMP_ADDR_HI: rdata_o = mtimecmp.half.hi;
      default:                   rdata_o = '0;
    endcase
  end

  // a written half takes the bus value instead of the count
  always_comb begin
    mtime_n.full = mtime.full + 64'd1;
    if (wr_en && req_i.addr == mem_pkg::MTIME_ADDR_LO) begin
      mtime_n.half.lo = req_i.wdata;
    end
    if (wr_en && req_i.addr == mem_pkg::MTIME_ADDR_HI) begin
      mtime_n.half.hi = req_i.wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      mtime.full    <= '0;
      mtimecmp.full <= '1;   // no interrupt until programmed
      timer_irq_o   <= 1'b0;
    end else begin
      mtime <= mtime_n;
      if (wr_en && req_i.addr == mem_pkg::MTIMECMP_ADDR_LO) begin
        mtimecmp.half.lo <= req_i.wdata;
      end
      if (wr_en && req_i.addr == mem_pkg::MTIMECMP_ADDR_HI) begin
        mtimecmp.half.hi <= req_i.wdata;
      end
      timer_irq_o <= (mtime.full >= mtimecmp.full);
    end
  end

endmodule

`default_nettype wire

/* src/data_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module data_ram (
  input  logic                     clk,
  input  logic                     reset_i,
  input  mem_pkg::dmem_req_t       req_i,
  output logic                     ready_o,
  output logic [mem_pkg::XLEN-1:0] rdata_o
);

  logic [3:0][7:0]            mem [mem_pkg::RAM_WORDS];
  logic [mem_pkg::RAM_AW-1:0] word_idx;
  logic [3:0][7:0]            wbytes;
  logic                       sample;

  assign word_idx = req_i.addr[mem_pkg::RAM_AW+1:2];
  assign wbytes   = req_i.wdata;
  assign sample   = req_i.valid & ~ready_o;  // new request, not yet answered

  // one-cycle answer pulse
  always_ff @(posedge clk) begin
    if (reset_i) begin
      ready_o <= 1'b0;
    end else begin
      ready_o <= sample;
    end
  end

  always_ff @(posedge clk) begin
    if (sample && req_i.we) begin
      for (int b = 0; b < 4; b++) begin
        if (req_i.mask[b]) begin
          mem[word_idx][b] <= wbytes[b];
        end
      end
    end
  end

  // read word held for the ready cycle
  always_ff @(posedge clk) begin
    if (sample && !req_i.we) begin
      rdata_o <= mem[word_idx];
    end
  end

endmodule

`default_nettype wire

/* src/mem_subsys_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top (
  input  logic             clk,
  input  logic             reset_i,
  input  mem_pkg::exmem_t  exmem_i,
  output mem_pkg::memwb_t  memwb_o,
  output logic             stall_o,
  output logic             timer_irq_o
);

  mem_pkg::dmem_req_t        dmem_req;
  logic                      dmem_ready;
  logic [mem_pkg::XLEN-1:0]  dmem_rdata;
  mem_pkg::clint_req_t       clint_req;
  logic [mem_pkg::XLEN-1:0]  clint_rdata;

  mem_stage u_mem_stage (
    .exmem_i       (exmem_i),
    .dmem_req_o    (dmem_req),
    .dmem_ready_i  (dmem_ready),
    .dmem_rdata_i  (dmem_rdata),
    .clint_req_o   (clint_req),
    .clint_rdata_i (clint_rdata),
    .memwb_o       (memwb_o),
    .stall_o       (stall_o)
  );

  data_ram u_data_ram (
    .clk     (clk),
    .reset_i (reset_i),
    .req_i   (dmem_req),
    .ready_o (dmem_ready),
    .rdata_o (dmem_rdata)
  );

  clint u_clint (
    .clk         (clk),
    .reset_i     (reset_i),
    .req_i       (clint_req),
    .rdata_o     (clint_rdata),
    .timer_irq_o (timer_irq_o)
  );

endmodule

`default_nettype wire
